// ==== Bender.yml ====
package:
  name: rfoc

sources:
  # packages first, the modules depend on them
  - common/rf_pkg.sv
  - common/oc_pkg.sv
  - register_file/register_file.sv
  - register_file/bank_arbiter.sv
  - collector/operand_collector.sv
  - collector/collector_array.sv
  - logic/dispatch_scheduler.sv
  - logic/rfoc_top.sv
  - target: simulation
    files:
      - verification/rfoc_tb.sv

// ==== collector/collector_array.sv ====
module collector_array (
    input  logic clk,
    input  logic rst,
    input  logic issue_valid,
    input  oc_pkg::issue_t issue,
    input  logic [oc_pkg::num_slots-1:0] grant,
    input  logic [rf_pkg::num_banks-1:0] ret_valid,
    input  rf_pkg::rd_tag_t ret_tag [rf_pkg::num_banks],
    input  rf_pkg::word_t ret_data [rf_pkg::num_banks],
    input  logic [oc_pkg::num_collectors-1:0] rel,
    output logic full,
    output rf_pkg::bank_read_t req [oc_pkg::num_slots],
    output logic [oc_pkg::num_collectors-1:0] ready,
    output logic [oc_pkg::num_collectors-1:0] is_mem,
    output oc_pkg::dispatch_t entries [oc_pkg::num_collectors]
);
    import rf_pkg::*;
    import oc_pkg::*;

    logic [num_collectors-1:0] busy;
    logic [num_collectors-1:0] load;
    logic [num_slots-1:0] slot_ret;
    word_t slot_data [num_slots];

    always_comb begin
        load = '0;
        if (issue_valid && !full) begin
            for (int c = num_collectors - 1; c >= 0; c--) begin
                if (!busy[c]) begin
                    load = '0;
                    load[c] = 1'b1;  // lowest free entry wins
                end
            end
        end
    end

    // steer bank returns by tag into slot {collector, src}
    always_comb begin
        slot_ret = '0;
        for (int s = 0; s < num_slots; s++) begin
            slot_data[s] = '0;
        end
        for (int b = 0; b < num_banks; b++) begin
            if (ret_valid[b]) begin
                slot_ret[{ret_tag[b].oc_id, ret_tag[b].slot}] = 1'b1;
                slot_data[{ret_tag[b].oc_id, ret_tag[b].slot}] = ret_data[b];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else begin
            full <= &((busy & ~rel) | load);
        end
    end

    for (genvar c = 0; c < num_collectors; c++) begin : g_oc
        bank_read_t oc_req [2];
        word_t oc_data [2];

        assign oc_data[0] = slot_data[2*c];
        assign oc_data[1] = slot_data[2*c+1];
        assign req[2*c] = oc_req[0];
        assign req[2*c+1] = oc_req[1];
        assign is_mem[c] = is_mem_class(entries[c].ins);

        operand_collector #(
            .id(collector_id_t'(c))
        ) u_oc (
            .clk(clk),
            .rst(rst),
            .load(load[c]),
            .issue(issue),
            .grant(grant[2*c +: 2]),
            .ret_valid(slot_ret[2*c +: 2]),
            .ret_data(oc_data),
            .rel(rel[c]),
            .busy(busy[c]),
            .ready(ready[c]),
            .req(oc_req),
            .entry(entries[c])
        );
    end

endmodule

// ==== collector/operand_collector.sv ====
module operand_collector #(
    parameter oc_pkg::collector_id_t id = '0
) (
    input  logic clk,
    input  logic rst,
    input  logic load,
    input  oc_pkg::issue_t issue,
    input  logic [1:0] grant,
    input  logic [1:0] ret_valid,
    input  rf_pkg::word_t ret_data [2],
    input  logic rel,  // dispatch release
    output logic busy,
    output logic ready,
    output rf_pkg::bank_read_t req [2],
    output oc_pkg::dispatch_t entry
);
    import rf_pkg::*;
    import oc_pkg::*;

    typedef enum logic [1:0] {
        st_pending,
        st_requested,
        st_present
    } slot_state_t;

    slot_state_t state [2];
    logic [1:0] has_src;  // slot needs a bank read
    rf_addr_t addr [2];
    word_t opnd [2];
    issue_t ins;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            has_src <= '0;
            state[0] <= st_present;
            state[1] <= st_present;
        end else if (load) begin
            busy <= 1'b1;
            has_src <= {issue.src2_valid, issue.src1_valid};
            state[0] <= st_pending;
            state[1] <= st_pending;
        end else begin
            if (rel) begin
                busy <= 1'b0;
            end
            // sourceless slots step through the same states without the bank
            for (int s = 0; s < 2; s++) begin
                case (state[s])
                    st_pending: begin
                        if (grant[s] || !has_src[s]) begin
                            state[s] <= st_requested;
                        end
                    end
                    st_requested: begin
                        if (ret_valid[s] || !has_src[s]) begin
                            state[s] <= st_present;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            ins <= issue;
            addr[0] <= rf_map(issue.warp, issue.src1);
            addr[1] <= rf_map(issue.warp, issue.src2);
            opnd[0] <= '0;
            opnd[1] <= '0;
        end else begin
            for (int s = 0; s < 2; s++) begin
                if (state[s] == st_requested && ret_valid[s]) begin
                    opnd[s] <= ret_data[s];
                end
            end
        end
    end

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            req[s].valid = busy && has_src[s] && state[s] == st_pending;
            req[s].bank = addr[s].bank;
            req[s].row = addr[s].row;
            req[s].oc_id = id;
        end
    end

    assign ready = busy && state[0] == st_present && state[1] == st_present;

    assign entry.ins = ins;
    assign entry.opnd_a = opnd[0];
    assign entry.opnd_b = opnd[1];

    a_load_free: assert property (@(posedge clk) disable iff (rst) load |-> !busy);

    a_rel_ready: assert property (@(posedge clk) disable iff (rst) rel |-> ready);

endmodule

// ==== common/oc_pkg.sv ====
package oc_pkg;

    localparam int num_collectors = 4;
    localparam int num_slots = 2 * num_collectors;  // two sources per collector

    typedef rf_pkg::oc_id_t collector_id_t;

    typedef struct packed {
        rf_pkg::warp_id_t warp;
        logic [31:0] instr;
        rf_pkg::reg_idx_t src1;
        logic src1_valid;
        rf_pkg::reg_idx_t src2;
        logic src2_valid;
        rf_pkg::reg_idx_t dst;
        logic [15:0] imme;
        logic imme_valid;
        logic [3:0] alu_op;
        logic reg_write;
        logic mem_write;
        logic mem_read;
        logic shared_global;
        logic beq;
        logic blt;
        logic [1:0] scb_id;
        rf_pkg::lane_mask_t active_mask;
    } issue_t;

    typedef struct packed {
        issue_t ins;
        rf_pkg::word_t opnd_a;
        rf_pkg::word_t opnd_b;
    } dispatch_t;

    // loads and stores go to the memory port
    function automatic logic is_mem_class(issue_t ins);
        return ins.mem_read | ins.mem_write;
    endfunction

endpackage

// ==== common/rf_pkg.sv ====
package rf_pkg;

    localparam int num_banks = 4;
    localparam int num_rows = 16;
    localparam int num_lanes = 8;
    localparam int lane_width = 32;
    localparam int num_warps = 8;
    localparam int num_arch_regs = 8;

    typedef logic [num_lanes*lane_width-1:0] word_t;
    typedef logic [$clog2(num_banks)-1:0] bank_id_t;
    typedef logic [$clog2(num_rows)-1:0] row_id_t;
    typedef logic [$clog2(num_warps)-1:0] warp_id_t;
    typedef logic [$clog2(num_arch_regs)-1:0] reg_idx_t;
    typedef logic [num_lanes-1:0] lane_mask_t;
    typedef logic [1:0] oc_id_t;  // collector number

    typedef struct packed {
        logic valid;
        warp_id_t warp;
        reg_idx_t reg_idx;
        lane_mask_t mask;  // per-lane write enable
        word_t data;
    } wb_t;

    typedef struct packed {
        bank_id_t bank;
        row_id_t row;
    } rf_addr_t;

    typedef struct packed {
        logic valid;
        bank_id_t bank;
        row_id_t row;
        oc_id_t oc_id;
    } bank_read_t;

    typedef struct packed {
        oc_id_t oc_id;
        logic slot;  // 0 src1, 1 src2
    } rd_tag_t;

    // bank rotates with the warp so equal indices of different warps spread out
    function automatic rf_addr_t rf_map(warp_id_t warp, reg_idx_t idx);
        rf_addr_t addr;
        addr.bank = bank_id_t'(idx + warp);
        addr.row = {warp, idx[2]};
        return addr;
    endfunction

endpackage

// ==== logic/dispatch_scheduler.sv ====
module dispatch_scheduler (
    input  logic clk,
    input  logic rst,
    input  logic [oc_pkg::num_collectors-1:0] ready,
    input  logic [oc_pkg::num_collectors-1:0] is_mem,
    input  oc_pkg::dispatch_t entries [oc_pkg::num_collectors],
    output logic [oc_pkg::num_collectors-1:0] rel,
    output logic alu_valid,
    output oc_pkg::dispatch_t alu_out,
    output logic mem_valid,
    output oc_pkg::dispatch_t mem_out
);
    import oc_pkg::*;

    collector_id_t alu_ptr;
    collector_id_t mem_ptr;
    collector_id_t alu_idx;
    collector_id_t mem_idx;
    logic alu_hit;
    logic mem_hit;

    // first candidate at or after ptr
    function automatic collector_id_t rr_pick(
        input logic [num_collectors-1:0] cand,
        input collector_id_t ptr
    );
        collector_id_t idx;
        collector_id_t pick;
        pick = ptr;
        for (int k = num_collectors - 1; k >= 0; k--) begin
            idx = ptr + collector_id_t'(k);
            if (cand[idx]) begin
                pick = idx;
            end
        end
        return pick;
    endfunction

    assign alu_hit = |(ready & ~is_mem);
    assign mem_hit = |(ready & is_mem);
    assign alu_idx = rr_pick(ready & ~is_mem, alu_ptr);
    assign mem_idx = rr_pick(ready & is_mem, mem_ptr);

    always_comb begin
        rel = '0;
        if (alu_hit) begin
            rel[alu_idx] = 1'b1;
        end
        if (mem_hit) begin
            rel[mem_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid <= 1'b0;
            mem_valid <= 1'b0;
            alu_ptr <= '0;
            mem_ptr <= '0;
        end else begin
            alu_valid <= alu_hit;
            mem_valid <= mem_hit;
            if (alu_hit) begin
                alu_ptr <= alu_idx + 1'b1;
            end
            if (mem_hit) begin
                mem_ptr <= mem_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alu_hit) begin
            alu_out <= entries[alu_idx];
        end
        if (mem_hit) begin
            mem_out <= entries[mem_idx];
        end
    end

    // a released entry drops out of ready so it cannot go out twice
    a_rel_clears: assert property (
        @(posedge clk) disable iff (rst)
        |rel |=> (ready & $past(rel)) == '0
    );

endmodule

// ==== logic/rfoc_top.sv ====
module rfoc_top (
    input  logic clk,
    input  logic rst,
    input  logic issue_valid,
    input  oc_pkg::issue_t issue,
    input  rf_pkg::wb_t wb,
    output logic full,
    output logic alu_valid,
    output oc_pkg::dispatch_t alu_out,
    output logic mem_valid,
    output oc_pkg::dispatch_t mem_out
);
    import rf_pkg::*;
    import oc_pkg::*;

    bank_read_t req [num_slots];
    logic [num_slots-1:0] grant;
    logic [num_banks-1:0] rd_en;
    row_id_t rd_row [num_banks];
    rd_tag_t rd_tag [num_banks];
    logic [num_banks-1:0] ret_valid;
    rd_tag_t ret_tag [num_banks];
    word_t ret_data [num_banks];
    logic [num_collectors-1:0] ready;
    logic [num_collectors-1:0] is_mem;
    logic [num_collectors-1:0] rel;
    dispatch_t entries [num_collectors];

    register_file u_rf (
        .clk(clk),
        .rst(rst),
        .wb(wb),
        .rd_en(rd_en),
        .rd_row(rd_row),
        .rd_tag(rd_tag),
        .ret_valid(ret_valid),
        .ret_tag(ret_tag),
        .ret_data(ret_data)
    );

    bank_arbiter u_arb (
        .clk(clk),
        .rst(rst),
        .wb(wb),
        .req(req),
        .rd_en(rd_en),
        .rd_row(rd_row),
        .rd_tag(rd_tag),
        .grant(grant)
    );

    collector_array u_oc_array (
        .clk(clk),
        .rst(rst),
        .issue_valid(issue_valid),
        .issue(issue),
        .grant(grant),
        .ret_valid(ret_valid),
        .ret_tag(ret_tag),
        .ret_data(ret_data),
        .rel(rel),
        .full(full),
        .req(req),
        .ready(ready),
        .is_mem(is_mem),
        .entries(entries)
    );

    dispatch_scheduler u_sched (
        .clk(clk),
        .rst(rst),
        .ready(ready),
        .is_mem(is_mem),
        .entries(entries),
        .rel(rel),
        .alu_valid(alu_valid),
        .alu_out(alu_out),
        .mem_valid(mem_valid),
        .mem_out(mem_out)
    );

endmodule

// ==== register_file/bank_arbiter.sv ====
module bank_arbiter (
    input  logic clk,
    input  logic rst,
    input  rf_pkg::wb_t wb,
    input  rf_pkg::bank_read_t req [oc_pkg::num_slots],
    output logic [rf_pkg::num_banks-1:0] rd_en,
    output rf_pkg::row_id_t rd_row [rf_pkg::num_banks],
    output rf_pkg::rd_tag_t rd_tag [rf_pkg::num_banks],
    output logic [oc_pkg::num_slots-1:0] grant
);
    import rf_pkg::*;
    import oc_pkg::*;

    localparam int slot_w = $clog2(num_slots);

    rf_addr_t wr_addr;
    logic [num_slots-1:0] hits [num_banks];
    logic [slot_w-1:0] ptr [num_banks];  // rr start per bank
    logic [slot_w-1:0] win [num_banks];

    assign wr_addr = rf_map(wb.warp, wb.reg_idx);

    always_comb begin
        logic [slot_w-1:0] idx;
        grant = '0;
        for (int b = 0; b < num_banks; b++) begin
            rd_en[b] = 1'b0;
            win[b] = '0;
            for (int s = 0; s < num_slots; s++) begin
                hits[b][s] = req[s].valid && req[s].bank == bank_id_t'(b);
            end
            for (int k = 0; k < num_slots; k++) begin
                idx = ptr[b] + slot_w'(k);
                if (!rd_en[b] && hits[b][idx]) begin
                    rd_en[b] = 1'b1;
                    win[b] = idx;
                end
            end
            if (wb.valid && wr_addr.bank == bank_id_t'(b)) begin
                rd_en[b] = 1'b0;  // write wins the bank
            end
            rd_row[b] = req[win[b]].row;
            rd_tag[b].oc_id = req[win[b]].oc_id;
            rd_tag[b].slot = win[b][0];
            if (rd_en[b]) begin
                grant[win[b]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int b = 0; b < num_banks; b++) begin
                ptr[b] <= '0;
            end
        end else begin
            for (int b = 0; b < num_banks; b++) begin
                if (rd_en[b]) begin
                    ptr[b] <= win[b] + 1'b1;
                end
            end
        end
    end

    for (genvar s = 0; s < num_slots; s++) begin : g_chk
        // a granted slot waits for its data and does not ask again
        a_grant_drops: assert property (
            @(posedge clk) disable iff (rst)
            grant[s] |=> !req[s].valid
        );
    end

endmodule

// ==== register_file/register_file.sv ====
module register_file (
    input  logic clk,
    input  logic rst,
    input  rf_pkg::wb_t wb,
    input  logic [rf_pkg::num_banks-1:0] rd_en,
    input  rf_pkg::row_id_t rd_row [rf_pkg::num_banks],
    input  rf_pkg::rd_tag_t rd_tag [rf_pkg::num_banks],
    output logic [rf_pkg::num_banks-1:0] ret_valid,
    output rf_pkg::rd_tag_t ret_tag [rf_pkg::num_banks],
    output rf_pkg::word_t ret_data [rf_pkg::num_banks]
);
    import rf_pkg::*;

    rf_addr_t wr_addr;
    logic [num_banks-1:0] wr_bank;

    assign wr_addr = rf_map(wb.warp, wb.reg_idx);

    always_comb begin
        wr_bank = '0;
        if (wb.valid) begin
            wr_bank[wr_addr.bank] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ret_valid <= '0;
        end else begin
            ret_valid <= rd_en;  // data follows one cycle after grant
        end
    end

    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        word_t mem [num_rows];

        always_ff @(posedge clk) begin
            if (wr_bank[b]) begin
                for (int l = 0; l < num_lanes; l++) begin
                    if (wb.mask[l]) begin
                        mem[wr_addr.row][l*lane_width +: lane_width] <=
                            wb.data[l*lane_width +: lane_width];
                    end
                end
            end
        end

        always_ff @(posedge clk) begin
            if (rd_en[b]) begin
                ret_data[b] <= mem[rd_row[b]];
                ret_tag[b] <= rd_tag[b];
            end
        end

        // the arbiter must keep reads off a bank that takes a writeback
        a_no_read_on_write: assert property (
            @(posedge clk) disable iff (rst)
            !(rd_en[b] && wr_bank[b])
        );
    end

endmodule

// ==== verification/rfoc_tb.sv ====
module rfoc_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rf_pkg::*;
    import oc_pkg::*;

    localparam int clk_period = 4;
    localparam int timeout_cycles = 200;
    localparam int max_issues = 1024;

    logic clk;
    logic rst;
    logic issue_valid;
    issue_t issue;
    wb_t wb;
    logic full;
    logic alu_valid;
    logic mem_valid;
    dispatch_t alu_out;
    dispatch_t mem_out;

    word_t model [num_warps][num_arch_regs];  // reference register contents
    issue_t exp_ins [max_issues];
    word_t exp_a [max_issues];
    word_t exp_b [max_issues];
    time issue_time [max_issues];
    bit done [max_issues];
    int live [$];  // ids issued, not yet dispatched
    int issued;
    int dispatched;
    int checks;
    int errors;
    int timeouts;

    rfoc_top UUT (
        .clk(clk),
        .rst(rst),
        .issue_valid(issue_valid),
        .issue(issue),
        .wb(wb),
        .full(full),
        .alu_valid(alu_valid),
        .alu_out(alu_out),
        .mem_valid(mem_valid),
        .mem_out(mem_out)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic expect_bit(input string name, input logic exp, input logic act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[FAIL] %0t %s: expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic expect_word(input string name, input word_t exp, input word_t act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[FAIL] %0t %s: expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic expect_ins(input string name, input issue_t exp, input issue_t act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[FAIL] %0t %s: expected %h, got %h", $time, name, exp, act);
        end
    endtask

    function automatic word_t rand_word();
        word_t w;
        for (int l = 0; l < num_lanes; l++) begin
            w[l*lane_width +: lane_width] = $urandom;
        end
        return w;
    endfunction

    // true when an outstanding instruction still has to read this register
    function automatic bit reg_in_use(input warp_id_t w, input reg_idx_t r);
        issue_t ins;
        foreach (live[i]) begin
            ins = exp_ins[live[i]];
            if (ins.warp == w && ((ins.src1_valid && ins.src1 == r) ||
                                  (ins.src2_valid && ins.src2 == r))) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        issue_valid <= 1'b0;
        wb.valid <= 1'b0;
    endtask

    task automatic drive_write(input warp_id_t w, input reg_idx_t r, input lane_mask_t mask);
        wb_t next_wb;
        next_wb.valid = 1'b1;
        next_wb.warp = w;
        next_wb.reg_idx = r;
        next_wb.mask = mask;
        next_wb.data = rand_word();
        for (int l = 0; l < num_lanes; l++) begin
            if (mask[l]) begin
                model[w][r][l*lane_width +: lane_width] = next_wb.data[l*lane_width +: lane_width];
            end
        end
        wb <= next_wb;
    endtask

    task automatic drive_issue(input warp_id_t w, input reg_idx_t s1, input logic v1,
                               input reg_idx_t s2, input logic v2);
        issue_t ins;
        ins.warp = w;
        ins.instr = 32'(issued);  // instr carries the tracking id
        ins.src1 = s1;
        ins.src1_valid = v1;
        ins.src2 = s2;
        ins.src2_valid = v2;
        ins.dst = reg_idx_t'($urandom);
        ins.imme = 16'($urandom);
        ins.imme_valid = 1'($urandom);
        ins.alu_op = 4'($urandom);
        ins.reg_write = 1'($urandom);
        ins.mem_write = ($urandom % 5) == 0;
        ins.mem_read = ($urandom % 4) == 0;
        ins.shared_global = 1'($urandom);
        ins.beq = 1'($urandom);
        ins.blt = 1'($urandom);
        ins.scb_id = 2'(issued);
        ins.active_mask = lane_mask_t'($urandom);
        exp_ins[issued] = ins;
        exp_a[issued] = v1 ? model[w][s1] : '0;  // snapshot at issue
        exp_b[issued] = v2 ? model[w][s2] : '0;
        issue_time[issued] = $time;
        done[issued] = 1'b0;
        live.push_back(issued);
        issued++;
        issue_valid <= 1'b1;
        issue <= ins;
    endtask

    task automatic random_cycle();
        warp_id_t w;
        reg_idx_t r;
        next_cycle();
        if (issued - dispatched < num_collectors && issued < max_issues && $urandom % 4 != 0) begin
            drive_issue(warp_id_t'($urandom), reg_idx_t'($urandom), ($urandom % 8) != 0,
                        reg_idx_t'($urandom), ($urandom % 8) != 0);
        end
        w = warp_id_t'($urandom);
        r = reg_idx_t'($urandom);
        if ($urandom % 3 == 0 && !reg_in_use(w, r)) begin
            drive_write(w, r, lane_mask_t'($urandom));
        end
    endtask

    task automatic wait_space();
        int n;
        n = 0;
        next_cycle();
        while (issued - dispatched >= num_collectors && timeouts == 0) begin
            n++;
            if (n > timeout_cycles) begin
                timeouts++;
                $display("timeout: no collector freed within %0d cycles", timeout_cycles);
            end else begin
                next_cycle();
            end
        end
    endtask

    task automatic check_dispatch(input dispatch_t d, input logic on_mem);
        int id;
        int pos;
        string port;
        id = int'(d.ins.instr);
        pos = 0;
        port = on_mem ? "mem_out" : "alu_out";
        checks++;
        if (id < 0 || id >= issued || done[id]) begin
            errors++;
            $display("instruction %0d dispatched on %s but not outstanding at %0t", id, port, $time);
            return;
        end
        expect_bit("mem_valid", exp_ins[id].mem_read | exp_ins[id].mem_write, on_mem);
        expect_ins({port, ".ins"}, exp_ins[id], d.ins);
        expect_word({port, ".opnd_a"}, exp_a[id], d.opnd_a);
        expect_word({port, ".opnd_b"}, exp_b[id], d.opnd_b);
        checks++;
        assert ($time - issue_time[id] <= time'(timeout_cycles * clk_period)) else begin
            errors++;
            $display("instruction %0d took longer than %0d cycles to dispatch", id, timeout_cycles);
        end
        done[id] = 1'b1;
        dispatched++;
        for (int i = 0; i < live.size(); i++) begin
            if (live[i] == id) begin
                pos = i;
            end
        end
        live.delete(pos);
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (alu_valid) begin
                check_dispatch(alu_out, 1'b0);
            end
            if (mem_valid) begin
                check_dispatch(mem_out, 1'b1);
            end
            // an issue still on the inputs is not yet in a collector
            expect_bit("full", (issued - dispatched - int'(issue_valid)) == num_collectors, full);
            checks++;
            assert (!(issue_valid && full)) else begin
                errors++;
                $display("issue driven while full is high at %0t", $time);
            end
        end
    end

    initial begin
        int n;
        clk = 1'b0;
        rst = 1'b1;
        issue_valid = 1'b0;
        issue = '0;
        wb = '0;
        issued = 0;
        dispatched = 0;
        checks = 0;
        errors = 0;
        timeouts = 0;
        void'($urandom(31201));
        repeat (16) begin
            @(posedge clk);
        end
        rst <= 1'b0;
        @(negedge clk);
        expect_bit("full", 1'b0, full);
        expect_bit("alu_valid", 1'b0, alu_valid);
        expect_bit("mem_valid", 1'b0, mem_valid);

        for (int w = 0; w < num_warps; w++) begin
            for (int r = 0; r < num_arch_regs; r++) begin
                next_cycle();
                drive_write(warp_id_t'(w), reg_idx_t'(r), '1);
            end
        end

        next_cycle();
        drive_write(3'd2, 3'd5, 8'hA5);  // partial lanes
        next_cycle();
        drive_issue(3'd2, 3'd5, 1'b1, 3'd1, 1'b1);

        // all sources below map to bank 0 so the entries pile up
        for (int w = 0; w < num_collectors; w++) begin
            wait_space();
            if (timeouts == 0) begin
                drive_issue(warp_id_t'(w), reg_idx_t'((4 - w) % 4), 1'b1,
                            reg_idx_t'((4 - w) % 4 + 4), 1'b1);
            end
        end

        repeat (600) begin
            if (timeouts == 0) begin
                random_cycle();
            end
        end

        n = 0;
        while (issued != dispatched && timeouts == 0) begin
            n++;
            if (n > timeout_cycles) begin
                timeouts++;
                $display("timeout: %0d instructions never dispatched", issued - dispatched);
            end else begin
                next_cycle();
            end
        end
        repeat (8) begin
            next_cycle();  // room for a stray second dispatch
        end

        $display("checks: %0d  errors: %0d  timeouts: %0d  issued: %0d  dispatched: %0d",
                 checks, errors, timeouts, issued, dispatched);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
common/rf_pkg.sv
common/oc_pkg.sv
register_file/register_file.sv
register_file/bank_arbiter.sv
collector/operand_collector.sv
collector/collector_array.sv
logic/dispatch_scheduler.sv
logic/rfoc_top.sv
verification/rfoc_tb.sv
